// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --assert -j 0
TOP       = tb_ooo_core
FILELIST  = files.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// ==== alu_unit.sv ====
//////////////////////////////////////////////////
// Single-cycle ALU. Completes in the cycle its
// issue valid is seen
//////////////////////////////////////////////////
`timescale 1ns/1ps

module alu_unit (
    issue_if.unit          iss,
    output logic           done,
    output ooo_pkg::id_t   id,
    output ooo_pkg::data_t result
);
    import ooo_pkg::*;

    assign done = iss.alu_valid;
    assign id   = iss.id;

    always_comb begin
        case (iss.op)
            // Add and subtract wrap at DATA_W
            OP_ADD: result = iss.op_a + iss.op_b;
            OP_SUB: result = iss.op_a - iss.op_b;
            OP_AND: result = iss.op_a & iss.op_b;
            OP_OR:  result = iss.op_a | iss.op_b;
            OP_XOR: result = iss.op_a ^ iss.op_b;
            // Signed less than
            OP_SLT: result = data_t'($signed(iss.op_a) < $signed(iss.op_b));
            // Multiply opcodes never carry alu_valid
            default: result = '0;
        endcase
    end

endmodule

// ==== files.f ====
ooo_pkg.sv
tracking_if.sv
issue_if.sv
id_tracking.sv
issue_decode.sv
alu_unit.sv
mul_unit.sv
write_back.sv
ooo_core_top.sv
tb_ooo_core.sv

// ==== id_tracking.sv ====
//////////////////////////////////////////////////
// In-order ID allocator. Hands out the next free ID
// and tracks the oldest one still in flight
//////////////////////////////////////////////////
`timescale 1ns/1ps

module id_tracking (
    input  logic         clk,
    input  logic         rst,
    input  logic         issued,
    input  logic         retired,
    output ooo_pkg::id_t next_id,
    output ooo_pkg::id_t oldest_id,
    output logic         id_available,
    output logic         empty
);
    import ooo_pkg::*;

    // Zero to MAX_INFLIGHT needs one extra bit
    logic [ID_W:0] inflight_count;

    always_ff @(posedge clk) begin
        if (rst) begin
            next_id        <= '0;
            oldest_id      <= '0;
            inflight_count <= '0;
        end else begin
            // Both counters wrap modulo MAX_INFLIGHT
            next_id   <= next_id + id_t'(issued);
            oldest_id <= oldest_id + id_t'(retired);
            if (issued && !retired)
                inflight_count <= inflight_count + 1'b1;
            else if (!issued && retired)
                inflight_count <= inflight_count - 1'b1;
        end
    end

    assign id_available = (inflight_count != (ID_W+1)'(MAX_INFLIGHT));
    assign empty        = (inflight_count == '0);

    // Decode must respect the free ID, write-back must have something to retire
    a_no_issue_full: assert property (@(posedge clk) disable iff (rst) issued |-> id_available)
        else $error("ID issued with all IDs in flight");
    a_no_retire_empty: assert property (@(posedge clk) disable iff (rst) retired |-> !empty)
        else $error("Retire with no ID in flight");

endmodule

// ==== issue_decode.sv ====
//////////////////////////////////////////////////
// Accepts one instruction at a time, picks the unit
// from the opcode and registers the issue into the
// execution units one cycle later
//////////////////////////////////////////////////
`timescale 1ns/1ps

module issue_decode (
    input  logic             clk,
    input  logic             rst,
    input  logic             instr_valid,
    input  ooo_pkg::op_t     instr_op,
    input  ooo_pkg::rd_addr_t instr_rd,
    input  ooo_pkg::data_t   op_a,
    input  ooo_pkg::data_t   op_b,
    input  logic             mul_busy,
    output logic             issue_ready,
    tracking_if.decode       ti,
    issue_if.decode          iss
);
    import ooo_pkg::*;

    logic      is_mul;
    unit_sel_t unit;
    logic      accept;
    logic      alu_valid_r;
    // Multiply registered but not yet seen by the multiplier
    logic      mul_valid_r;

    //////////////////////////////////////////////////
    // Decode and ready
    //////////////////////////////////////////////////
    assign is_mul = (instr_op == OP_MUL) || (instr_op == OP_MULH);
    assign unit   = is_mul ? MUL_UNIT : ALU_UNIT;

    // Multiplier takes one op at a time
    assign issue_ready = ti.id_available && (!is_mul || !(mul_busy || mul_valid_r));
    assign accept      = instr_valid && issue_ready;

    // Allocation request toward write-back
    assign ti.issued     = accept;
    assign ti.issue_unit = unit;
    assign ti.issue_rd   = instr_rd;

    //////////////////////////////////////////////////
    // Issue register
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            alu_valid_r <= 1'b0;
            mul_valid_r <= 1'b0;
        end else begin
            alu_valid_r <= accept && !is_mul;
            mul_valid_r <= accept && is_mul;
        end
    end

    // Payload only, loaded with the allocated ID
    always_ff @(posedge clk) begin
        if (accept) begin
            iss.id   <= ti.issue_id;
            iss.op   <= instr_op;
            iss.op_a <= op_a;
            iss.op_b <= op_b;
        end
    end

    assign iss.alu_valid = alu_valid_r;
    assign iss.mul_valid = mul_valid_r;

endmodule

// ==== issue_if.sv ====
//////////////////////////////////////////////////
// Registered operation from decode to the execution
// units. One valid per unit, chosen in decode
//////////////////////////////////////////////////
`timescale 1ns/1ps

interface issue_if;
    import ooo_pkg::*;

    logic  alu_valid;
    logic  mul_valid;
    // Shared payload
    id_t   id;
    op_t   op;
    data_t op_a;
    data_t op_b;

    modport decode (output alu_valid, output mul_valid,
                    output id, output op, output op_a, output op_b);
    modport unit (input alu_valid, input mul_valid,
                  input id, input op, input op_a, input op_b);
endinterface

// ==== mul_unit.sv ====
//////////////////////////////////////////////////
// Iterative shift-add multiplier. Latency follows
// the top set bit of op_b, 1 to 16 cycles
//////////////////////////////////////////////////
`timescale 1ns/1ps

module mul_unit (
    input  logic           clk,
    input  logic           rst,
    issue_if.unit          iss,
    output logic           busy,
    output logic           done,
    output ooo_pkg::id_t   id,
    output ooo_pkg::data_t result
);
    import ooo_pkg::*;

    mul_state_t              state;
    // Shifted multiplicand and partial product
    logic [2*DATA_W-1:0]     mcand;
    logic [2*DATA_W-1:0]     acc;
    logic [2*DATA_W-1:0]     sum;
    // Remaining multiplier bits
    data_t                   mplier;
    id_t                     op_id;
    logic                    want_high;

    // This step's partial product
    assign sum = acc + (mplier[0] ? mcand : '0);

    // Finished once no multiplier bits remain after this step
    assign busy   = (state == MUL_BUSY);
    assign done   = busy && (mplier[DATA_W-1:1] == '0);
    assign id     = op_id;
    assign result = want_high ? sum[2*DATA_W-1:DATA_W] : sum[DATA_W-1:0];

    always_ff @(posedge clk) begin
        if (rst)
            state <= MUL_IDLE;
        else if (state == MUL_IDLE && iss.mul_valid)
            state <= MUL_BUSY;
        else if (done)
            state <= MUL_IDLE;
    end

    always_ff @(posedge clk) begin
        if (state == MUL_IDLE && iss.mul_valid) begin
            mcand     <= {{DATA_W{1'b0}}, iss.op_a};
            mplier    <= iss.op_b;
            acc       <= '0;
            op_id     <= iss.id;
            want_high <= (iss.op == OP_MULH);
        end else if (busy) begin
            acc    <= sum;
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    // Decode holds multiplies off while the unit works
    a_no_valid_busy: assert property (@(posedge clk) disable iff (rst) iss.mul_valid |-> !busy)
        else $error("Multiply issued while multiplier busy");

endmodule

// ==== ooo_core_top.sv ====
//////////////////////////////////////////////////
// Core top level. Decode, ALU, multiplier and the
// write-back block joined by plain ports
//////////////////////////////////////////////////
`timescale 1ns/1ps

module ooo_core_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              instr_valid,
    input  ooo_pkg::op_t      instr_op,
    input  ooo_pkg::rd_addr_t instr_rd,
    input  ooo_pkg::data_t    op_a,
    input  ooo_pkg::data_t    op_b,
    output logic              issue_ready,
    output logic              retire_valid,
    output ooo_pkg::id_t      retire_id,
    output ooo_pkg::rd_addr_t retire_rd,
    output ooo_pkg::data_t    retire_data,
    output logic              empty
);
    import ooo_pkg::*;

    tracking_if ti ();
    issue_if    iss ();

    logic  mul_busy;
    // Completion by unit number
    logic  unit_done [NUM_WB_UNITS-1:0];
    id_t   unit_id [NUM_WB_UNITS-1:0];
    data_t unit_result [NUM_WB_UNITS-1:0];

    // Decode
    issue_decode u_decode (
        .clk, .rst, .instr_valid, .instr_op, .instr_rd, .op_a, .op_b,
        .mul_busy, .issue_ready, .ti(ti.decode), .iss(iss.decode)
    );

    // Execute
    alu_unit u_alu (
        .iss    (iss.unit),
        .done   (unit_done[ALU_UNIT]),
        .id     (unit_id[ALU_UNIT]),
        .result (unit_result[ALU_UNIT])
    );

    mul_unit u_mul (
        .clk, .rst, .iss(iss.unit), .busy(mul_busy),
        .done   (unit_done[MUL_UNIT]),
        .id     (unit_id[MUL_UNIT]),
        .result (unit_result[MUL_UNIT])
    );

    // Commit and retire
    write_back u_wb (
        .clk, .rst, .unit_done, .unit_id, .unit_result, .ti(ti.wb),
        .retire_valid, .retire_id, .retire_rd, .retire_data, .empty
    );

endmodule

// ==== ooo_pkg.sv ====
//////////////////////////////////////////////////
// Shared widths, counts, opcodes and types for the
// out-of-order completion core. Modules import it
// inside their bodies and use scoped names in ports
//////////////////////////////////////////////////

package ooo_pkg;

    // Datapath and ID sizing
    localparam int DATA_W       = 16;
    localparam int MAX_INFLIGHT = 8;
    localparam int ID_W         = 3;
    localparam int NUM_WB_UNITS = 2;

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [ID_W-1:0]   id_t;
    typedef logic [4:0]        rd_addr_t;
    typedef logic              unit_sel_t;
    typedef logic [2:0]        op_t;

    // Unit numbers, also the index into completion arrays
    localparam unit_sel_t ALU_UNIT = 1'b0;
    localparam unit_sel_t MUL_UNIT = 1'b1;

    //////////////////////////////////////////////////
    // Opcodes
    //////////////////////////////////////////////////
    localparam op_t OP_ADD  = 3'd0;
    localparam op_t OP_SUB  = 3'd1;
    localparam op_t OP_AND  = 3'd2;
    localparam op_t OP_OR   = 3'd3;
    localparam op_t OP_XOR  = 3'd4;
    // Signed compare, result is 1 or 0
    localparam op_t OP_SLT  = 3'd5;
    // Low half of product
    localparam op_t OP_MUL  = 3'd6;
    // High half of unsigned product
    localparam op_t OP_MULH = 3'd7;

    // Multiplier sequencing
    typedef enum logic {
        MUL_IDLE,
        MUL_BUSY
    } mul_state_t;

endpackage

// ==== tb_ooo_core.sv ====
//////////////////////////////////////////////////
// Testbench for the out-of-order completion core.
// Directed corners, then random instructions
// checked in order against a queue model
//////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_ooo_core;
    import ooo_pkg::*;

    localparam int NUM_INSTR   = 300;
    localparam int CYCLE_LIMIT = NUM_INSTR * 20 + 100;

    // One expected retire per accepted instruction
    typedef struct packed {
        id_t      id;
        rd_addr_t rd;
        data_t    data;
    } expect_t;

    logic     clk;
    logic     rst;
    logic     instr_valid;
    op_t      instr_op;
    rd_addr_t instr_rd;
    data_t    op_a;
    data_t    op_b;
    logic     issue_ready;
    logic     retire_valid;
    id_t      retire_id;
    rd_addr_t retire_rd;
    data_t    retire_data;
    logic     empty;

    expect_t model_q [$];
    id_t     next_exp_id;
    int      accepted_count;
    int      retired_count;
    int      cycle_count;
    logic    full_seen;

    ooo_core_top dut (
        .clk, .rst, .instr_valid, .instr_op, .instr_rd, .op_a, .op_b,
        .issue_ready, .retire_valid, .retire_id, .retire_rd, .retire_data, .empty
    );

    always #20 clk = ~clk;

    //////////////////////////////////////////////////
    // Reference model and checks
    //////////////////////////////////////////////////
    function automatic data_t expected_result(op_t op, data_t a, data_t b);
        logic [2*DATA_W-1:0] prod;
        prod = (2*DATA_W)'(a) * (2*DATA_W)'(b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLT:  return ($signed(a) < $signed(b)) ? data_t'(1) : data_t'(0);
            OP_MUL:  return prod[DATA_W-1:0];
            default: return prod[2*DATA_W-1:DATA_W];
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Fail at %0t ns: %s is %0h, expected %0h", $time, name, actual, expected);
            $display("STATUS: FAIL");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // Corner values show up often
    function automatic data_t random_operand();
        case ($urandom_range(0, 7))
            0:       return 16'h0000;
            1:       return 16'hffff;
            2:       return 16'h8000;
            3:       return 16'h7fff;
            default: return data_t'($urandom());
        endcase
    endfunction

    // Monitor runs mid-cycle on settled DUT outputs
    always @(negedge clk) begin
        int      inflight;
        expect_t head;
        if (!rst) begin
            // IDs held after the last edge
            // A retire pulse on that edge has already freed its ID
            inflight = accepted_count - retired_count - int'(retire_valid);
            if (inflight == MAX_INFLIGHT) begin
                full_seen = 1'b1;
                check_value("issue_ready", 32'(issue_ready), 32'd0);
            end else if (instr_op != OP_MUL && instr_op != OP_MULH) begin
                check_value("issue_ready", 32'(issue_ready), 32'd1);
            end
            if (retire_valid) begin
                if (model_q.size() == 0) begin
                    $display("Retire pulse seen with no instruction outstanding at %0t ns", $time);
                    $display("STATUS: FAIL");
                    $fatal(1, "Unexpected retire");
                end
                head = model_q.pop_front();
                check_value("retire_id", 32'(retire_id), 32'(head.id));
                check_value("retire_rd", 32'(retire_rd), 32'(head.rd));
                check_value("retire_data", 32'(retire_data), 32'(head.data));
                retired_count++;
            end
            // Accepted at the coming edge
            if (instr_valid && issue_ready) begin
                model_q.push_back('{next_exp_id, instr_rd,
                                    expected_result(instr_op, op_a, op_b)});
                next_exp_id = next_exp_id + 1'b1;
                accepted_count++;
            end
        end
    end

    // Run length guard
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, %0d of %0d instructions retired",
                     cycle_count, retired_count, NUM_INSTR);
            $display("STATUS: FAIL");
            $fatal(1, "Timeout");
        end
    end

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////
    // Hold the instruction until the DUT takes it
    task automatic send_instr(input op_t op, input rd_addr_t rd, input data_t a, input data_t b);
        logic accepted;
        accepted    = 1'b0;
        instr_valid = 1'b1;
        instr_op    = op;
        instr_rd    = rd;
        op_a        = a;
        op_b        = b;
        while (!accepted) begin
            @(negedge clk);
            accepted = issue_ready;
            @(posedge clk);
            #1;
        end
        instr_valid = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    initial begin
        op_t op;
        void'($urandom(32'h20f8b30b));
        clk            = 1'b0;
        rst            = 1'b1;
        instr_valid    = 1'b0;
        instr_op       = OP_ADD;
        instr_rd       = '0;
        op_a           = '0;
        op_b           = '0;
        next_exp_id    = '0;
        accepted_count = 0;
        retired_count  = 0;
        cycle_count    = 0;
        full_seen      = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        // Long multiply first
        // Young ALU ops finish ahead and fill all IDs
        send_instr(OP_MULH, 5'd1, 16'hffff, 16'hffff);
        send_instr(OP_ADD,  5'd2, 16'hffff, 16'h0001);
        send_instr(OP_SUB,  5'd3, 16'h0000, 16'h0001);
        send_instr(OP_SLT,  5'd4, 16'h8000, 16'h0001);
        send_instr(OP_SLT,  5'd5, 16'h0001, 16'h8000);
        send_instr(OP_AND,  5'd6, 16'hf0f0, 16'h3c3c);
        send_instr(OP_OR,   5'd7, 16'hf0f0, 16'h3c3c);
        send_instr(OP_XOR,  5'd8, 16'hf0f0, 16'h3c3c);
        send_instr(OP_ADD,  5'd9, 16'h1234, 16'h4321);
        send_instr(OP_MUL,  5'd10, 16'h0000, 16'hffff);

        // Random mix with roughly a third multiplies
        for (int i = 10; i < NUM_INSTR; i++) begin
            if ($urandom_range(0, 2) == 0)
                op = op_t'($urandom_range(6, 7));
            else
                op = op_t'($urandom_range(0, 5));
            send_instr(op, rd_addr_t'($urandom_range(0, 31)), random_operand(),
                       random_operand());
            if ($urandom_range(0, 1) == 1)
                idle_cycles($urandom_range(1, 4));
        end

        // Drain until the DUT reports no ID in flight
        while (!empty) begin
            @(posedge clk);
            #1;
        end
        idle_cycles(10);
        @(negedge clk);
        check_value("empty", 32'(empty), 32'd1);

        if (model_q.size() != 0) begin
            $display("Model queue still holds %0d instructions at the end", model_q.size());
            $display("STATUS: FAIL");
            $fatal(1, "Leftover instructions");
        end else if (!full_seen) begin
            $display("All IDs were never in flight at once");
            $display("STATUS: FAIL");
            $fatal(1, "Full condition not reached");
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

// ==== tracking_if.sv ====
//////////////////////////////////////////////////
// ID allocation and issue metadata between decode
// and write-back
//////////////////////////////////////////////////
`timescale 1ns/1ps

interface tracking_if;
    import ooo_pkg::*;

    // Allocation side, driven by write-back
    logic      id_available;
    id_t       issue_id;
    // Issue side, driven by decode
    logic      issued;
    unit_sel_t issue_unit;
    rd_addr_t  issue_rd;

    modport decode (input id_available, input issue_id,
                    output issued, output issue_unit, output issue_rd);
    modport wb (output id_available, output issue_id,
                input issued, input issue_unit, input issue_rd);
endinterface

// ==== write_back.sv ====
//////////////////////////////////////////////////
// ID-indexed commit buffer. Units complete out of
// order by ID and results retire in issue order
// on a one-cycle retire pulse
//////////////////////////////////////////////////
`timescale 1ns/1ps

module write_back (
    input  logic              clk,
    input  logic              rst,
    input  logic              unit_done [ooo_pkg::NUM_WB_UNITS-1:0],
    input  ooo_pkg::id_t      unit_id [ooo_pkg::NUM_WB_UNITS-1:0],
    input  ooo_pkg::data_t    unit_result [ooo_pkg::NUM_WB_UNITS-1:0],
    tracking_if.wb            ti,
    output logic              retire_valid,
    output ooo_pkg::id_t      retire_id,
    output ooo_pkg::rd_addr_t retire_rd,
    output ooo_pkg::data_t    retire_data,
    output logic              empty
);
    import ooo_pkg::*;

    // Per-ID metadata and results
    unit_sel_t id_unit_select [MAX_INFLIGHT-1:0];
    rd_addr_t  id_rd [MAX_INFLIGHT-1:0];
    data_t     results_by_id [MAX_INFLIGHT-1:0];

    logic [MAX_INFLIGHT-1:0] id_issued_one_hot;
    logic [MAX_INFLIGHT-1:0] id_writing;
    logic [MAX_INFLIGHT-1:0] id_pending;
    logic [MAX_INFLIGHT-1:0] id_pending_r;
    logic [MAX_INFLIGHT-1:0] id_retiring_one_hot;
    logic [MAX_INFLIGHT-1:0] id_inuse;

    id_t  oldest_id;
    id_t  id_retiring;
    logic retiring_next;

    //////////////////////////////////////////////////
    // Completion and issue decode per ID
    //////////////////////////////////////////////////
    always_comb begin
        id_writing = '0;
        for (int i = 0; i < MAX_INFLIGHT; i++) begin
            for (int j = 0; j < NUM_WB_UNITS; j++) begin
                id_writing[i] |= unit_done[j] && (unit_id[j] == ID_W'(i));
            end
        end
    end

    always_comb begin
        id_issued_one_hot = '0;
        id_issued_one_hot[ti.issue_id] = ti.issued;
    end

    // Unit and destination recorded at issue, result muxed by recorded unit
    always_ff @(posedge clk) begin
        for (int i = 0; i < MAX_INFLIGHT; i++) begin
            if (id_issued_one_hot[i]) begin
                id_unit_select[i] <= ti.issue_unit;
                id_rd[i]          <= ti.issue_rd;
            end
            if (id_writing[i])
                results_by_id[i] <= unit_result[id_unit_select[i]];
        end
    end

    //////////////////////////////////////////////////
    // Pending tracking and retire
    //////////////////////////////////////////////////
    assign id_pending    = id_writing | (id_pending_r & ~id_retiring_one_hot);
    // Oldest is either done now or already waiting
    assign retiring_next = id_pending[oldest_id];

    always_ff @(posedge clk) begin
        if (rst) begin
            id_pending_r <= '0;
            retire_valid <= 1'b0;
            id_inuse     <= '0;
        end else begin
            id_pending_r <= id_pending;
            retire_valid <= retiring_next;
            // A freed ID may be handed out again on the same edge
            id_inuse     <= (id_inuse & ~id_retiring_one_hot) | id_issued_one_hot;
        end
    end

    always_ff @(posedge clk) begin
        id_retiring <= oldest_id;
    end

    always_comb begin
        id_retiring_one_hot = '0;
        id_retiring_one_hot[id_retiring] = retire_valid;
    end

    assign retire_id   = id_retiring;
    assign retire_rd   = id_rd[id_retiring];
    assign retire_data = results_by_id[id_retiring];

    // Order of IDs, next free and oldest
    id_tracking id_counters (
        .clk          (clk),
        .rst          (rst),
        .issued       (ti.issued),
        .retired      (retiring_next),
        .next_id      (ti.issue_id),
        .oldest_id    (oldest_id),
        .id_available (ti.id_available),
        .empty        (empty)
    );

    // A unit may only complete an ID that is live and not yet done
    for (genvar j = 0; j < NUM_WB_UNITS; j++) begin : g_done_check
        a_done_issued: assert property (@(posedge clk) disable iff (rst)
            unit_done[j] |-> id_inuse[unit_id[j]] && !id_pending_r[unit_id[j]])
            else $error("Unit %0d completed an ID that is not in flight", j);
    end

endmodule
